//--- hw/i2c_cfg.svh
// Register map, status and command bit positions
// Queue depth and reset value of the prescaler
`ifndef I2C_CFG_SVH
`define I2C_CFG_SVH

// Word addresses on the 3-bit Wishbone bus
`define I2C_REG_STATUS   3'd0
`define I2C_REG_CMD      3'd2
`define I2C_REG_DATA     3'd4
`define I2C_REG_PRESCALE 3'd6

// Status register fields
`define I2C_ST_BUSY     0
`define I2C_ST_MISS_ACK 3
`define I2C_ST_CMD_FULL 9
`define I2C_ST_CMD_OVF  10
`define I2C_ST_WR_FULL  12
`define I2C_ST_WR_OVF   13

// Command register fields, address in bits 6..0
`define I2C_CMD_ADDR_MSB 6
`define I2C_CMD_START    8
`define I2C_CMD_WRITE    10
`define I2C_CMD_STOP     12

// Entries per queue, power of two
`define I2C_FIFO_DEPTH 4

// Clock cycles per quarter SCL period after reset
`define I2C_DEFAULT_PRESCALE 16'd1

`endif

//--- hw/i2c_pkg.sv
// Shared types of the I2C write master
// Vector typedefs, queued command layout, engine states
`default_nettype none

package i2c_pkg;

    // Host side
    typedef logic [2:0]  wb_addr_t;
    typedef logic [15:0] wb_data_t;
    typedef logic [1:0]  wb_sel_t;

    // I2C side
    typedef logic [6:0]  i2c_addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] prescale_t;

    // Queued command, address in the low bits
    typedef logic [9:0]  cmd_word_t;

    localparam int CMD_ADDR_MSB  = 6;
    localparam int CMD_START_BIT = 7;
    localparam int CMD_WRITE_BIT = 8;
    localparam int CMD_STOP_BIT  = 9;

    // Bit engine sequencer
    typedef enum logic [2:0] {IDLE, START, SHIFT, ACK, STOP} engine_state_t;

endpackage

`default_nettype wire

//--- hw/i2c_feed_if.sv
// Queue to engine streams
// Command words and write data bytes, valid/ready each
`default_nettype none

interface i2c_feed_if import i2c_pkg::*; ();

    // Command stream
    cmd_word_t cmd_word;
    logic      cmd_valid;
    logic      cmd_ready;

    // Write data stream
    byte_t     tx_byte;
    logic      tx_valid;
    logic      tx_ready;

    // Queue side offers words
    modport queue (output cmd_word, cmd_valid, tx_byte, tx_valid,
                   input  cmd_ready, tx_ready);

    // Engine side takes them
    modport engine (input  cmd_word, cmd_valid, tx_byte, tx_valid,
                    output cmd_ready, tx_ready);

endinterface

`default_nettype wire

//--- hw/i2c_fifo.sv
// Synchronous valid/ready FIFO
// Circular buffer with occupancy count
`default_nettype none

module i2c_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] in_data_i,
    input  logic             in_valid_i,
    output logic             in_ready_o,
    output logic [WIDTH-1:0] out_data_o,
    output logic             out_valid_o,
    input  logic             out_ready_i
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    // Flow control straight from the count
    assign in_ready_o  = (count != FULL_COUNT);
    assign out_valid_o = (count != '0);
    assign push        = in_valid_i && in_ready_o;
    assign pop         = out_valid_o && out_ready_i;

    // Head entry shown without a read cycle
    assign out_data_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap by width
            if (push) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            if (push && !pop) begin
                count <= count + (PTR_W + 1)'(1);
            end else if (pop && !push) begin
                count <= count - (PTR_W + 1)'(1);
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/i2c_wb_regs.sv
// Wishbone register block of the I2C write master
// Status with sticky flags, command and data push, prescale
`default_nettype none

`include "i2c_cfg.svh"

module i2c_wb_regs import i2c_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  wb_addr_t  wbs_adr_i,
    input  wb_data_t  wbs_dat_i,
    output wb_data_t  wbs_dat_o,
    input  logic      wbs_we_i,
    input  wb_sel_t   wbs_sel_i,
    input  logic      wbs_stb_i,
    input  logic      wbs_cyc_i,
    output logic      wbs_ack_o,
    output cmd_word_t cmd_word_o,
    output logic      cmd_valid_o,
    input  logic      cmd_ready_i,
    output byte_t     tx_byte_o,
    output logic      tx_valid_o,
    input  logic      tx_ready_i,
    input  logic      busy_i,
    input  logic      miss_ack_i,
    output prescale_t prescale_o
);

    logic      ack_q;
    wb_data_t  dat_q;
    wb_data_t  rd_data;
    logic      acc;
    logic      wr_acc;
    logic      st_wr;
    logic      cmd_wr;
    cmd_word_t cmd_q;
    cmd_word_t cmd_d;
    prescale_t prescale_q;
    logic      miss_q;
    logic      cmd_ovf_q;
    logic      wr_ovf_q;

    // New access only while ack is low, so ack toggles
    assign acc    = wbs_cyc_i && wbs_stb_i && !ack_q;
    assign wr_acc = acc && wbs_we_i;
    assign st_wr  = wr_acc && (wbs_adr_i == `I2C_REG_STATUS);
    assign cmd_wr = wr_acc && (wbs_adr_i == `I2C_REG_CMD);

    // Command merges written lanes over the last word
    always_comb begin
        cmd_d = cmd_q;
        if (wbs_sel_i[0]) begin
            cmd_d[CMD_ADDR_MSB:0] = wbs_dat_i[`I2C_CMD_ADDR_MSB:0];
        end
        if (wbs_sel_i[1]) begin
            cmd_d[CMD_START_BIT] = wbs_dat_i[`I2C_CMD_START];
            cmd_d[CMD_WRITE_BIT] = wbs_dat_i[`I2C_CMD_WRITE];
            cmd_d[CMD_STOP_BIT]  = wbs_dat_i[`I2C_CMD_STOP];
        end
    end

    // Pushes land on the edge that raises ack
    assign cmd_word_o  = cmd_d;
    assign cmd_valid_o = cmd_wr && wbs_sel_i[1] &&
                         (cmd_d[CMD_START_BIT] || cmd_d[CMD_WRITE_BIT] || cmd_d[CMD_STOP_BIT]);
    assign tx_byte_o   = wbs_dat_i[7:0];
    assign tx_valid_o  = wr_acc && (wbs_adr_i == `I2C_REG_DATA) && wbs_sel_i[0];

    // Read mux, data register reads as zero
    always_comb begin
        rd_data = '0;
        case (wbs_adr_i)
            `I2C_REG_STATUS: begin
                rd_data[`I2C_ST_BUSY]     = busy_i;
                rd_data[`I2C_ST_MISS_ACK] = miss_q;
                rd_data[`I2C_ST_CMD_FULL] = !cmd_ready_i;
                rd_data[`I2C_ST_CMD_OVF]  = cmd_ovf_q;
                rd_data[`I2C_ST_WR_FULL]  = !tx_ready_i;
                rd_data[`I2C_ST_WR_OVF]   = wr_ovf_q;
            end
            `I2C_REG_CMD: begin
                rd_data[`I2C_CMD_ADDR_MSB:0] = cmd_q[CMD_ADDR_MSB:0];
                rd_data[`I2C_CMD_START]      = cmd_q[CMD_START_BIT];
                rd_data[`I2C_CMD_WRITE]      = cmd_q[CMD_WRITE_BIT];
                rd_data[`I2C_CMD_STOP]       = cmd_q[CMD_STOP_BIT];
            end
            `I2C_REG_PRESCALE: rd_data = prescale_q;
            default: rd_data = '0;
        endcase
    end

    // Read data held for the ack cycle only
    always_ff @(posedge clk) begin
        dat_q <= (acc && !wbs_we_i) ? rd_data : '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q      <= 1'b0;
            cmd_q      <= '0;
            prescale_q <= `I2C_DEFAULT_PRESCALE;
            miss_q     <= 1'b0;
            cmd_ovf_q  <= 1'b0;
            wr_ovf_q   <= 1'b0;
        end else begin
            ack_q <= wbs_cyc_i && wbs_stb_i && !ack_q;
            if (cmd_wr) begin
                cmd_q <= cmd_d;
            end
            if (wr_acc && (wbs_adr_i == `I2C_REG_PRESCALE)) begin
                if (wbs_sel_i[0]) begin
                    prescale_q[7:0] <= wbs_dat_i[7:0];
                end
                if (wbs_sel_i[1]) begin
                    prescale_q[15:8] <= wbs_dat_i[15:8];
                end
            end
            // Sticky flags, a new event beats a clear
            miss_q <= miss_ack_i ||
                      (miss_q && !(st_wr && wbs_sel_i[0] && wbs_dat_i[`I2C_ST_MISS_ACK]));
            cmd_ovf_q <= (cmd_valid_o && !cmd_ready_i) ||
                         (cmd_ovf_q && !(st_wr && wbs_sel_i[1] && wbs_dat_i[`I2C_ST_CMD_OVF]));
            wr_ovf_q <= (tx_valid_o && !tx_ready_i) ||
                        (wr_ovf_q && !(st_wr && wbs_sel_i[1] && wbs_dat_i[`I2C_ST_WR_OVF]));
        end
    end

    assign wbs_ack_o  = ack_q;
    assign wbs_dat_o  = dat_q;
    assign prescale_o = prescale_q;

endmodule

`default_nettype wire

//--- hw/i2c_byte_engine.sv
// Bit level I2C write master
// Quarter period prescaler and command sequencer
// Start or repeated start, address with W, data byte, ACK slots, stop
`default_nettype none

module i2c_byte_engine import i2c_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    i2c_feed_if.engine feed,
    input  prescale_t  prescale_i,
    input  logic       sda_i,
    output logic       scl_o,
    output logic       sda_o,
    output logic       busy_o,
    output logic       miss_ack_o
);

    engine_state_t state;
    prescale_t     cnt;
    logic          tick;
    logic [1:0]    quarter;
    logic [2:0]    bit_cnt;
    byte_t         shreg;
    i2c_addr_t     addr_q;
    logic          write_q;
    logic          stop_q;
    logic          held;
    logic          addr_phase;
    logic          load_data;
    logic          scl_q;
    logic          sda_q;
    logic          miss_q;

    // Commands taken only between transfers
    assign feed.cmd_ready = (state == IDLE);
    // Data byte fetched at the start of a data shift
    assign feed.tx_ready  = (state == SHIFT) && load_data;

    // One tick per quarter SCL period
    assign tick = (cnt == '0);

    always_ff @(posedge clk) begin
        if (rst || state == IDLE) begin
            cnt <= '0;
        end else if (tick) begin
            cnt <= (prescale_i != '0) ? prescale_i - 16'd1 : '0;
        end else begin
            cnt <= cnt - 16'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            quarter    <= 2'd0;
            held       <= 1'b0;
            addr_phase <= 1'b0;
            load_data  <= 1'b0;
            scl_q      <= 1'b1;
            sda_q      <= 1'b1;
            miss_q     <= 1'b0;
        end else begin
            miss_q <= 1'b0;
            case (state)
                IDLE: begin
                    quarter <= 2'd0;
                    if (feed.cmd_valid) begin
                        addr_q  <= feed.cmd_word[CMD_ADDR_MSB:0];
                        write_q <= feed.cmd_word[CMD_WRITE_BIT];
                        stop_q  <= feed.cmd_word[CMD_STOP_BIT];
                        // Start forced, or implied by a write on a free bus
                        if (feed.cmd_word[CMD_START_BIT] ||
                            (!held && feed.cmd_word[CMD_WRITE_BIT])) begin
                            state <= START;
                        end else if (feed.cmd_word[CMD_WRITE_BIT]) begin
                            // Held bus, data goes out without address
                            state      <= SHIFT;
                            load_data  <= 1'b1;
                            addr_phase <= 1'b0;
                        end else begin
                            state <= STOP;
                        end
                    end
                end
                START: begin
                    if (tick) begin
                        quarter <= quarter + 2'd1;
                        // SDA high first so a held bus sees a repeated start
                        if (quarter == 2'd0) begin
                            sda_q <= 1'b1;
                        end else if (quarter == 2'd1) begin
                            scl_q <= 1'b1;
                        end else if (quarter == 2'd2) begin
                            sda_q <= 1'b0;
                        end else begin
                            scl_q      <= 1'b0;
                            held       <= 1'b1;
                            shreg      <= {addr_q, 1'b0};
                            bit_cnt    <= 3'd7;
                            addr_phase <= 1'b1;
                            state      <= SHIFT;
                        end
                    end
                end
                SHIFT: begin
                    if (load_data) begin
                        // Stall with SCL low until a byte arrives
                        if (feed.tx_valid) begin
                            shreg     <= feed.tx_byte;
                            bit_cnt   <= 3'd7;
                            load_data <= 1'b0;
                        end
                    end else if (tick) begin
                        quarter <= quarter + 2'd1;
                        // MSB first, SDA changes only while SCL low
                        if (quarter == 2'd0) begin
                            sda_q <= shreg[7];
                        end else if (quarter == 2'd1) begin
                            scl_q <= 1'b1;
                        end else if (quarter == 2'd3) begin
                            scl_q <= 1'b0;
                            shreg <= {shreg[6:0], 1'b0};
                            if (bit_cnt == 3'd0) begin
                                state <= ACK;
                            end else begin
                                bit_cnt <= bit_cnt - 3'd1;
                            end
                        end
                    end
                end
                ACK: begin
                    if (tick) begin
                        quarter <= quarter + 2'd1;
                        if (quarter == 2'd0) begin
                            sda_q <= 1'b1;
                        end else if (quarter == 2'd1) begin
                            scl_q <= 1'b1;
                        end else if (quarter == 2'd2) begin
                            // Sample at SCL high point, released line is a NACK
                            miss_q <= sda_i;
                        end else begin
                            scl_q <= 1'b0;
                            if (addr_phase && write_q) begin
                                state      <= SHIFT;
                                load_data  <= 1'b1;
                                addr_phase <= 1'b0;
                            end else if (stop_q) begin
                                state <= STOP;
                            end else begin
                                // Keep the bus, SCL stays low
                                state <= IDLE;
                            end
                        end
                    end
                end
                STOP: begin
                    if (!held) begin
                        // Nothing to release
                        state <= IDLE;
                    end else if (tick) begin
                        quarter <= quarter + 2'd1;
                        if (quarter == 2'd0) begin
                            sda_q <= 1'b0;
                        end else if (quarter == 2'd1) begin
                            scl_q <= 1'b1;
                        end else if (quarter == 2'd2) begin
                            sda_q <= 1'b1;
                        end else begin
                            held  <= 1'b0;
                            state <= IDLE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign scl_o      = scl_q;
    assign sda_o      = sda_q;
    assign busy_o     = (state != IDLE);
    assign miss_ack_o = miss_q;

endmodule

`default_nettype wire

//--- hw/i2c_wbs_top.sv
// Top level of the Wishbone I2C write master
// Register block, command and data queues, bit engine
`default_nettype none

`include "i2c_cfg.svh"

module i2c_wbs_top import i2c_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  wb_addr_t wbs_adr_i,
    input  wb_data_t wbs_dat_i,
    output wb_data_t wbs_dat_o,
    input  logic     wbs_we_i,
    input  wb_sel_t  wbs_sel_i,
    input  logic     wbs_stb_i,
    output logic     wbs_ack_o,
    input  logic     wbs_cyc_i,
    input  logic     i2c_sda_i,
    output logic     i2c_scl_o,
    output logic     i2c_sda_o
);

    // Push side of the queues
    cmd_word_t cmd_push_word;
    logic      cmd_push_valid;
    logic      cmd_push_ready;
    byte_t     tx_push_byte;
    logic      tx_push_valid;
    logic      tx_push_ready;

    // Engine status and setup
    logic      busy;
    logic      miss_ack;
    prescale_t prescale;

    i2c_feed_if feed ();

    i2c_wb_regs i_regs (
        .clk(clk),
        .rst(rst),
        .wbs_adr_i(wbs_adr_i),
        .wbs_dat_i(wbs_dat_i),
        .wbs_dat_o(wbs_dat_o),
        .wbs_we_i(wbs_we_i),
        .wbs_sel_i(wbs_sel_i),
        .wbs_stb_i(wbs_stb_i),
        .wbs_cyc_i(wbs_cyc_i),
        .wbs_ack_o(wbs_ack_o),
        .cmd_word_o(cmd_push_word),
        .cmd_valid_o(cmd_push_valid),
        .cmd_ready_i(cmd_push_ready),
        .tx_byte_o(tx_push_byte),
        .tx_valid_o(tx_push_valid),
        .tx_ready_i(tx_push_ready),
        .busy_i(busy),
        .miss_ack_i(miss_ack),
        .prescale_o(prescale)
    );

    i2c_fifo #(.WIDTH($bits(cmd_word_t)), .DEPTH(`I2C_FIFO_DEPTH)) cmd_queue (
        .clk(clk),
        .rst(rst),
        .in_data_i(cmd_push_word),
        .in_valid_i(cmd_push_valid),
        .in_ready_o(cmd_push_ready),
        .out_data_o(feed.cmd_word),
        .out_valid_o(feed.cmd_valid),
        .out_ready_i(feed.cmd_ready)
    );

    i2c_fifo #(.WIDTH($bits(byte_t)), .DEPTH(`I2C_FIFO_DEPTH)) tx_queue (
        .clk(clk),
        .rst(rst),
        .in_data_i(tx_push_byte),
        .in_valid_i(tx_push_valid),
        .in_ready_o(tx_push_ready),
        .out_data_o(feed.tx_byte),
        .out_valid_o(feed.tx_valid),
        .out_ready_i(feed.tx_ready)
    );

    i2c_byte_engine i_engine (
        .clk(clk),
        .rst(rst),
        .feed(feed.engine),
        .prescale_i(prescale),
        .sda_i(i2c_sda_i),
        .scl_o(i2c_scl_o),
        .sda_o(i2c_sda_o),
        .busy_o(busy),
        .miss_ack_o(miss_ack)
    );

endmodule

`default_nettype wire

//--- verif/i2c_wbs_assert.sv
// Concurrent checks on the top-level ports
// Wishbone ack shape, released I2C lines after reset and while idle
`default_nettype none

module i2c_wbs_assert (
    input logic clk,
    input logic rst,
    input logic wbs_cyc_i,
    input logic wbs_stb_i,
    input logic wbs_ack_i,
    input logic scl_i,
    input logic sda_i,
    input logic busy_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // Ack lasts one cycle
    ack_single: assert property (@(posedge clk) disable iff (rst)
        wbs_ack_i |=> !wbs_ack_i)
        else $error("Wishbone ack high for two cycles");

    // Ack only answers a request
    ack_requested: assert property (@(posedge clk) disable iff (rst)
        $rose(wbs_ack_i) |-> $past(wbs_cyc_i && wbs_stb_i))
        else $error("Wishbone ack without cyc and stb");

    // Both lines released out of reset
    lines_after_reset: assert property (@(posedge clk)
        rst |=> (scl_i && sda_i))
        else $error("I2C lines not released after reset");

    // Free bus keeps SCL high until a command starts
    scl_idle: assert property (@(posedge clk) disable iff (rst)
        (!busy_i && scl_i) |=> scl_i)
        else $error("SCL dropped while the engine was idle");

endmodule

`default_nettype wire

//--- verif/i2c_wbs_tb.sv
// Directed testbench of the Wishbone I2C write master
// Wishbone access tasks, I2C slave model, LFSR data, compare tasks, tests
`default_nettype none

`include "i2c_cfg.svh"

module i2c_wbs_tb import i2c_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int        WAIT_LIMIT = 100;
    localparam int        IDLE_LIMIT = 1000;
    localparam i2c_addr_t SLAVE_ADDR = 7'h50;

    logic     clk;
    logic     rst;
    wb_addr_t wbs_adr;
    wb_data_t wbs_dat_w;
    wb_data_t wbs_dat_r;
    logic     wbs_we;
    wb_sel_t  wbs_sel;
    logic     wbs_stb;
    logic     wbs_cyc;
    logic     wbs_ack;
    logic     sda_in;
    logic     scl_out;
    logic     sda_out;

    // Slave model state
    logic  scl_prev;
    logic  sda_prev;
    logic  sl_release;
    logic  addr_match;
    logic  ack_wait;
    logic  ack_slot;
    int    bit_cnt;
    int    byte_idx;
    int    start_cnt;
    int    stop_cnt;
    byte_t sh;
    byte_t rx_bytes[$];

    // Random data source
    byte_t lfsr_q;

    i2c_wbs_top i_i2c_wbs_top (
        .clk(clk),
        .rst(rst),
        .wbs_adr_i(wbs_adr),
        .wbs_dat_i(wbs_dat_w),
        .wbs_dat_o(wbs_dat_r),
        .wbs_we_i(wbs_we),
        .wbs_sel_i(wbs_sel),
        .wbs_stb_i(wbs_stb),
        .wbs_ack_o(wbs_ack),
        .wbs_cyc_i(wbs_cyc),
        .i2c_sda_i(sda_in),
        .i2c_scl_o(scl_out),
        .i2c_sda_o(sda_out)
    );

    bind i2c_wbs_top i2c_wbs_assert i_assert (
        .clk(clk),
        .rst(rst),
        .wbs_cyc_i(wbs_cyc_i),
        .wbs_stb_i(wbs_stb_i),
        .wbs_ack_i(wbs_ack_o),
        .scl_i(i2c_scl_o),
        .sda_i(i2c_sda_o),
        .busy_i(busy)
    );

    always #5 clk = ~clk;

    // I2C slave, samples both lines once per clock
    always @(posedge clk) begin
        if (rst) begin
            scl_prev   = 1'b1;
            sda_prev   = 1'b1;
            sl_release = 1'b1;
            ack_wait   = 1'b0;
            ack_slot   = 1'b0;
            bit_cnt    = 0;
        end else begin
            if (scl_prev && scl_out && sda_prev && !sda_out) begin
                // Start or repeated start
                start_cnt++;
                bit_cnt  = 0;
                byte_idx = 0;
                ack_wait = 1'b0;
                ack_slot = 1'b0;
            end else if (scl_prev && scl_out && !sda_prev && sda_out) begin
                stop_cnt++;
                bit_cnt = 0;
            end else if (!scl_prev && scl_out && !ack_wait && !ack_slot) begin
                sh = {sh[6:0], sda_out};
                bit_cnt++;
                if (bit_cnt == 8) begin
                    rx_bytes.push_back(sh);
                    // Address byte decides the ACKs of the whole transfer
                    if (byte_idx == 0) begin
                        addr_match = (sh[7:1] == SLAVE_ADDR);
                    end
                    byte_idx++;
                    bit_cnt  = 0;
                    ack_wait = 1'b1;
                end
            end else if (scl_prev && !scl_out) begin
                // SCL low, ACK slot opens or closes
                if (ack_wait) begin
                    ack_wait   = 1'b0;
                    ack_slot   = 1'b1;
                    sl_release = !addr_match;
                end else if (ack_slot) begin
                    ack_slot   = 1'b0;
                    sl_release = 1'b1;
                end
            end
            scl_prev = scl_out;
            sda_prev = sda_out;
        end
        // Wired AND of master and slave
        sda_in <= sda_out & sl_release;
    end

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_reg(input string test, input wb_data_t exp, input wb_data_t act);
        if (act !== exp) begin
            $display("** Error: %s expected %h actual %h", test, exp, act);
            abort_run();
        end
    endtask

    task automatic check_byte(input string test, input byte_t exp, input byte_t act);
        if (act !== exp) begin
            $display("** Error: %s expected %h actual %h", test, exp, act);
            abort_run();
        end
    endtask

    task automatic check_count(input string test, input int exp, input int act);
        if (act != exp) begin
            $display("** Error: %s expected %0d actual %0d", test, exp, act);
            abort_run();
        end
    endtask

    // One Wishbone access, held until ack
    task automatic wb_access(input wb_addr_t adr, input wb_data_t dat, input wb_sel_t sel,
                             input logic we, output wb_data_t rd);
        int waited;
        waited = 0;
        @(posedge clk);
        wbs_adr   <= adr;
        wbs_dat_w <= dat;
        wbs_sel   <= sel;
        wbs_we    <= we;
        wbs_cyc   <= 1'b1;
        wbs_stb   <= 1'b1;
        @(negedge clk);
        while (!wbs_ack && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (!wbs_ack) begin
            $display("No Wishbone ack at address %0d", adr);
            abort_run();
        end else begin
            rd = wbs_dat_r;
            @(posedge clk);
            wbs_cyc <= 1'b0;
            wbs_stb <= 1'b0;
            wbs_we  <= 1'b0;
        end
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t dat, input wb_sel_t sel);
        wb_data_t unused;
        wb_access(adr, dat, sel, 1'b1, unused);
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t rd);
        wb_access(adr, '0, 2'b11, 1'b0, rd);
    endtask

    // Poll busy until the engine is done
    task automatic wait_idle(input string test);
        wb_data_t st;
        int polls;
        polls = 0;
        wb_read(`I2C_REG_STATUS, st);
        while (st[`I2C_ST_BUSY] && polls < IDLE_LIMIT) begin
            polls++;
            wb_read(`I2C_REG_STATUS, st);
        end
        if (st[`I2C_ST_BUSY]) begin
            $display("Transfer in %s never finished", test);
            abort_run();
        end
    endtask

    // Galois form, taps for x^8 + x^6 + x^5 + x^4 + 1
    function automatic byte_t lfsr_step(input byte_t s);
        lfsr_step = s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic random_byte(output byte_t b);
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    function automatic wb_data_t bit_mask(input int pos);
        bit_mask = '0;
        bit_mask[pos] = 1'b1;
    endfunction

    // Start and write to addr, stop optional
    function automatic wb_data_t write_cmd(input i2c_addr_t addr, input logic stop);
        write_cmd = bit_mask(`I2C_CMD_START) | bit_mask(`I2C_CMD_WRITE) | {9'd0, addr};
        if (stop) begin
            write_cmd = write_cmd | bit_mask(`I2C_CMD_STOP);
        end
    endfunction

    // Full write of one random byte, slave record cleared first
    task automatic send_byte(input string test, input i2c_addr_t addr, output byte_t data);
        random_byte(data);
        rx_bytes.delete();
        start_cnt = 0;
        stop_cnt  = 0;
        wb_write(`I2C_REG_DATA, {8'h00, data}, 2'b01);
        wb_write(`I2C_REG_CMD, write_cmd(addr, 1'b1), 2'b11);
        wait_idle(test);
    endtask

    task automatic reset_values();
        wb_data_t rd;
        wb_read(`I2C_REG_STATUS, rd);
        check_reg("reset status", '0, rd);
        wb_read(`I2C_REG_PRESCALE, rd);
        check_reg("reset prescale", `I2C_DEFAULT_PRESCALE, rd);
    endtask

    task automatic prescale_lanes();
        wb_data_t rd;
        wb_write(`I2C_REG_PRESCALE, 16'h1234, 2'b11);
        wb_read(`I2C_REG_PRESCALE, rd);
        check_reg("prescale both lanes", 16'h1234, rd);
        // Low lane only, high byte keeps its value
        wb_write(`I2C_REG_PRESCALE, 16'h5678, 2'b01);
        wb_read(`I2C_REG_PRESCALE, rd);
        check_reg("prescale low lane", 16'h1278, rd);
        wb_write(`I2C_REG_PRESCALE, 16'd2, 2'b11);
    endtask

    task automatic write_transfer();
        byte_t    data;
        wb_data_t st;
        send_byte("write transfer", SLAVE_ADDR, data);
        check_count("write transfer bytes", 2, rx_bytes.size());
        check_byte("write transfer address", 8'hA0, rx_bytes[0]);
        check_byte("write transfer data", data, rx_bytes[1]);
        check_count("write transfer starts", 1, start_cnt);
        check_count("write transfer stops", 1, stop_cnt);
        wb_read(`I2C_REG_STATUS, st);
        check_reg("write transfer status", '0, st);
    endtask

    task automatic missed_ack();
        byte_t    data;
        wb_data_t st;
        send_byte("missed ack", 7'h23, data);
        check_count("missed ack bytes", 2, rx_bytes.size());
        check_byte("missed ack address", 8'h46, rx_bytes[0]);
        wb_read(`I2C_REG_STATUS, st);
        check_reg("missed ack flag", bit_mask(`I2C_ST_MISS_ACK), st);
        wb_write(`I2C_REG_STATUS, bit_mask(`I2C_ST_MISS_ACK), 2'b11);
        wb_read(`I2C_REG_STATUS, st);
        check_reg("missed ack clear", '0, st);
    endtask

    task automatic wr_queue_overflow();
        wb_data_t st;
        byte_t    data;
        // One byte more than the queue holds
        for (int i = 0; i < `I2C_FIFO_DEPTH + 1; i++) begin
            random_byte(data);
            wb_write(`I2C_REG_DATA, {8'h00, data}, 2'b01);
        end
        wb_read(`I2C_REG_STATUS, st);
        check_reg("write overflow", bit_mask(`I2C_ST_WR_FULL) | bit_mask(`I2C_ST_WR_OVF), st);
        wb_write(`I2C_REG_STATUS, bit_mask(`I2C_ST_WR_OVF), 2'b10);
        wb_read(`I2C_REG_STATUS, st);
        check_reg("write overflow clear", bit_mask(`I2C_ST_WR_FULL), st);
    endtask

    task automatic cmd_queue_overflow();
        wb_data_t mask;
        wb_data_t st;
        mask = bit_mask(`I2C_ST_CMD_FULL) | bit_mask(`I2C_ST_CMD_OVF) | bit_mask(`I2C_ST_BUSY);
        // Engine takes the first, queue fills, last one is lost
        for (int i = 0; i < `I2C_FIFO_DEPTH + 2; i++) begin
            wb_write(`I2C_REG_CMD, write_cmd(SLAVE_ADDR, 1'b0), 2'b11);
        end
        wb_read(`I2C_REG_STATUS, st);
        check_reg("command overflow", mask, st & mask);
        wb_write(`I2C_REG_STATUS, bit_mask(`I2C_ST_CMD_OVF), 2'b10);
        wb_read(`I2C_REG_STATUS, st);
        check_reg("command overflow clear", mask & ~bit_mask(`I2C_ST_CMD_OVF), st & mask);
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        wbs_adr    = '0;
        wbs_dat_w  = '0;
        wbs_we     = 1'b0;
        wbs_sel    = '0;
        wbs_stb    = 1'b0;
        wbs_cyc    = 1'b0;
        sda_in     = 1'b1;
        sl_release = 1'b1;
        addr_match = 1'b0;
        byte_idx   = 0;
        start_cnt  = 0;
        stop_cnt   = 0;
        sh         = '0;
        lfsr_q     = 8'd56;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        reset_values();
        prescale_lanes();
        write_transfer();
        missed_ack();
        wr_queue_overflow();
        cmd_queue_overflow();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+hw
hw/i2c_pkg.sv
hw/i2c_feed_if.sv
hw/i2c_fifo.sv
hw/i2c_wb_regs.sv
hw/i2c_byte_engine.sv
hw/i2c_wbs_top.sv
verif/i2c_wbs_assert.sv
verif/i2c_wbs_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert
TOP       = i2c_wbs_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = Test OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
